// ==== core_config.svh ====
`ifndef CORE_CONFIG_SVH
`define CORE_CONFIG_SVH

`define CORE_XLEN       32              // Data and address width.
`define CORE_RESET_PC   32'h0000_0000   // First fetch address.
`define CORE_NOP_INSTR  32'h0000_0013   // addi x0, x0, 0.

`endif

// ==== isaPkg.sv ====
package isaPkg;

    // Major opcodes of the supported subset.
    typedef enum logic [6:0] {
        OP_LOAD    = 7'b0000011,
        OP_CUSTOM0 = 7'b0001011,
        OP_IMM     = 7'b0010011,
        OP_STORE   = 7'b0100011,
        OP_REG     = 7'b0110011,
        OP_BRANCH  = 7'b1100011,
        OP_JAL     = 7'b1101111
    } opcodeT;

    typedef enum logic [2:0] {
        BR_EQ = 3'b000,
        BR_NE = 3'b001,
        BR_LT = 3'b100,
        BR_GE = 3'b101
    } branchFunctT;

    // funct3 of the neuron operations on custom-0.
    typedef enum logic [2:0] {
        NR_SETTH = 3'b000,
        NR_ACCUM = 3'b001,
        NR_FIRE  = 3'b010
    } neuronFunctT;

endpackage

// ==== pipePkg.sv ====
package pipePkg;

    typedef enum logic [2:0] {
        ALU_ADD = 3'd0,     // Also the NOP operation.
        ALU_SUB = 3'd1,
        ALU_AND = 3'd2,
        ALU_OR  = 3'd3,
        ALU_XOR = 3'd4,
        ALU_SLT = 3'd5,
        ALU_SLL = 3'd6,
        ALU_SRL = 3'd7
    } aluFuncT;

    // Source of the execute-stage result.
    typedef enum logic [1:0] {
        PATH_ALU      = 2'd0,
        PATH_LINK     = 2'd1,
        PATH_MEMBRANE = 2'd2,
        PATH_FIRE     = 2'd3
    } exPathT;

endpackage

// ==== fetchSequencer.sv ====
`timescale 1ns/1ps
`include "core_config.svh"

module fetchSequencer (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  stall,
    input  logic                  redirectE,
    input  logic [`CORE_XLEN-1:0] targetE,
    output logic [`CORE_XLEN-1:0] fetchPc,
    output logic [`CORE_XLEN-1:0] pcD,
    output logic                  validD,
    output logic                  flushE
);

    localparam logic [`CORE_XLEN-1:0] pcStep = 4;

    // A redirect only takes effect on an edge that is not stalled.
    assign flushE = redirectE && !stall;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            fetchPc <= `CORE_RESET_PC;
            pcD     <= `CORE_RESET_PC;
            validD  <= 1'b0;
        end else if (!stall) begin
            fetchPc <= flushE ? targetE : fetchPc + pcStep;
            pcD     <= fetchPc;
            validD  <= !flushE;                 // Wrong-path word decodes as NOP.
        end
    end

    // A flush happens unstalled and kills the word that arrives in decode.
    assert property (@(posedge clk) disable iff (reset)
        flushE |-> !stall ##1 !validD);

endmodule

// ==== controlDecoder.sv ====
`timescale 1ns/1ps
`include "core_config.svh"

module controlDecoder
    import isaPkg::*;
    import pipePkg::*;
(
    input  logic [31:0]           instrD,
    input  logic                  validD,
    output logic                  regWriteExD,
    output logic                  regWriteWbD,
    output logic                  opBSrcD,
    output logic                  memWriteD,
    output logic                  enThresholdD,
    output logic                  msWriteD,
    output logic                  atWriteD,
    output logic                  branchD,
    output logic                  jumpD,
    output exPathT                exPathD,
    output aluFuncT               aluFuncD,
    output logic [2:0]            funct3D,
    output logic [`CORE_XLEN-1:0] immD,
    output logic [4:0]            rs1,
    output logic [4:0]            rs2,
    output logic [4:0]            rd
);

    opcodeT                opcode;
    logic [2:0]            funct3;
    logic [6:0]            funct7;
    logic                  rdNonZero;
    aluFuncT               aluSel;
    logic                  aluOk;
    logic [`CORE_XLEN-1:0] immI, immS, immB, immJ;

    assign opcode    = opcodeT'(instrD[6:0]);
    assign funct3    = instrD[14:12];
    assign funct7    = instrD[31:25];
    assign rs1       = instrD[19:15];
    assign rs2       = instrD[24:20];
    assign rd        = instrD[11:7];
    assign rdNonZero = (rd != 5'd0);

    assign immI = {{(`CORE_XLEN-12){instrD[31]}}, instrD[31:20]};
    assign immS = {{(`CORE_XLEN-12){instrD[31]}}, instrD[31:25], instrD[11:7]};
    assign immB = {{(`CORE_XLEN-13){instrD[31]}}, instrD[31], instrD[7],
                   instrD[30:25], instrD[11:8], 1'b0};
    assign immJ = {{(`CORE_XLEN-21){instrD[31]}}, instrD[31], instrD[19:12],
                   instrD[20], instrD[30:21], 1'b0};

    // ALU operation shared by the register and immediate forms.
    always_comb begin
        aluOk  = 1'b1;
        aluSel = ALU_ADD;
        case (funct3)
            3'b000:  aluSel = (opcode == OP_REG && funct7[5]) ? ALU_SUB : ALU_ADD;
            3'b001:  aluSel = ALU_SLL;
            3'b010:  aluSel = ALU_SLT;
            3'b100:  aluSel = ALU_XOR;
            3'b101:  aluSel = ALU_SRL;
            3'b110:  aluSel = ALU_OR;
            3'b111:  aluSel = ALU_AND;
            default: aluOk  = 1'b0;             // sltu and sltiu are not supported.
        endcase
        if (opcode == OP_REG)
            aluOk = aluOk && (funct7 == 7'd0 || (funct3 == 3'b000 && funct7 == 7'b0100000));
        else if (funct3 == 3'b001 || funct3 == 3'b101)
            aluOk = aluOk && (funct7 == 7'd0);  // No arithmetic shift.
    end

    always_comb begin
        regWriteExD  = 1'b0;
        regWriteWbD  = 1'b0;
        opBSrcD      = 1'b1;
        memWriteD    = 1'b0;
        enThresholdD = 1'b0;
        msWriteD     = 1'b0;
        atWriteD     = 1'b0;
        branchD      = 1'b0;
        jumpD        = 1'b0;
        exPathD      = PATH_ALU;
        aluFuncD     = ALU_ADD;
        funct3D      = 3'b000;
        immD         = '0;
        if (validD) begin
            case (opcode)
                OP_REG: if (aluOk) begin
                    regWriteExD = rdNonZero;
                    opBSrcD     = 1'b0;
                    aluFuncD    = aluSel;
                end
                OP_IMM: if (aluOk) begin
                    regWriteExD = rdNonZero;
                    aluFuncD    = aluSel;
                    immD        = immI;
                end
                OP_LOAD: if (funct3 == 3'b010) begin
                    regWriteWbD = rdNonZero;    // Result is the load address.
                    immD        = immI;
                end
                OP_STORE: if (funct3 == 3'b010) begin
                    memWriteD = 1'b1;
                    immD      = immS;
                end
                OP_BRANCH: if (funct3 inside {BR_EQ, BR_NE, BR_LT, BR_GE}) begin
                    branchD = 1'b1;
                    opBSrcD = 1'b0;
                    funct3D = funct3;
                    immD    = immB;
                end
                OP_JAL: begin
                    regWriteExD = rdNonZero;
                    jumpD       = 1'b1;
                    exPathD     = PATH_LINK;
                    immD        = immJ;
                end
                OP_CUSTOM0: begin
                    case (neuronFunctT'(funct3))
                        NR_SETTH: atWriteD = 1'b1;  // Returns rs1 through the ALU.
                        NR_ACCUM: begin
                            msWriteD = 1'b1;
                            exPathD  = PATH_MEMBRANE;
                        end
                        NR_FIRE: begin
                            enThresholdD = 1'b1;
                            exPathD      = PATH_FIRE;
                        end
                        default: ;
                    endcase
                    regWriteExD = rdNonZero && (funct3 inside {NR_SETTH, NR_ACCUM, NR_FIRE});
                end
                default: ;
            endcase
        end
    end

endmodule

// ==== idExControlRegister.sv ====
`timescale 1ns/1ps
`include "core_config.svh"

module idExControlRegister
    import pipePkg::*;
(
    input  logic       clk,
    input  logic       reset,
    input  logic       stallE,
    input  logic       flushE,
    input  logic       regWriteExD,
    input  logic       regWriteWbD,
    input  logic       opBSrcD,
    input  logic       memWriteD,
    input  logic       enThresholdD,
    input  logic       msWriteD,
    input  logic       atWriteD,
    input  logic       branchD,
    input  logic       jumpD,
    input  exPathT     exPathD,
    input  aluFuncT    aluFuncD,
    input  logic [2:0] funct3D,
    output logic       regWriteExE,
    output logic       regWriteWbE,
    output logic       opBSrcE,
    output logic       memWriteE,
    output logic       enThresholdE,
    output logic       msWriteE,
    output logic       atWriteE,
    output logic       branchE,
    output logic       jumpE,
    output exPathT     exPathE,
    output aluFuncT    aluFuncE,
    output logic [2:0] funct3E
);

    always_ff @(posedge clk or posedge reset) begin
        if (reset || flushE) begin
            regWriteExE  <= 1'b0;
            regWriteWbE  <= 1'b0;
            opBSrcE      <= 1'b1;               // NOP is addi x0, x0, 0.
            memWriteE    <= 1'b0;
            enThresholdE <= 1'b0;
            msWriteE     <= 1'b0;
            atWriteE     <= 1'b0;
            branchE      <= 1'b0;
            jumpE        <= 1'b0;
            exPathE      <= PATH_ALU;
            aluFuncE     <= ALU_ADD;
            funct3E      <= 3'b000;
        end else if (!stallE) begin
            regWriteExE  <= regWriteExD;
            regWriteWbE  <= regWriteWbD;
            opBSrcE      <= opBSrcD;
            memWriteE    <= memWriteD;
            enThresholdE <= enThresholdD;
            msWriteE     <= msWriteD;
            atWriteE     <= atWriteD;
            branchE      <= branchD;
            jumpE        <= jumpD;
            exPathE      <= exPathD;
            aluFuncE     <= aluFuncD;
            funct3E      <= funct3D;
        end
    end

    // A flushed slot must not write anything.
    assert property (@(posedge clk) disable iff (reset)
        flushE |=> !memWriteE && !regWriteExE && !regWriteWbE);

endmodule

// ==== idExDataRegister.sv ====
`timescale 1ns/1ps
`include "core_config.svh"

module idExDataRegister (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  stallE,
    input  logic [`CORE_XLEN-1:0] pcD,
    input  logic [`CORE_XLEN-1:0] rs1DataD,
    input  logic [`CORE_XLEN-1:0] rs2DataD,
    input  logic [`CORE_XLEN-1:0] immD,
    input  logic [4:0]            rd,
    output logic [`CORE_XLEN-1:0] pcE,
    output logic [`CORE_XLEN-1:0] rs1DataE,
    output logic [`CORE_XLEN-1:0] rs2DataE,
    output logic [`CORE_XLEN-1:0] immE,
    output logic [4:0]            rdE
);

    // No flush here; the control register turns a killed slot into a NOP.
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            pcE      <= '0;
            rs1DataE <= '0;
            rs2DataE <= '0;
            immE     <= '0;
            rdE      <= 5'd0;
        end else if (!stallE) begin
            pcE      <= pcD;
            rs1DataE <= rs1DataD;
            rs2DataE <= rs2DataD;
            immE     <= immD;
            rdE      <= rd;
        end
    end

endmodule

// ==== executeUnit.sv ====
`timescale 1ns/1ps
`include "core_config.svh"

module executeUnit
    import isaPkg::*;
    import pipePkg::*;
(
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  stall,
    input  logic                  opBSrcE,
    input  logic                  enThresholdE,
    input  logic                  msWriteE,
    input  logic                  atWriteE,
    input  logic                  branchE,
    input  logic                  jumpE,
    input  exPathT                exPathE,
    input  aluFuncT               aluFuncE,
    input  logic [2:0]            funct3E,
    input  logic [`CORE_XLEN-1:0] pcE,
    input  logic [`CORE_XLEN-1:0] rs1DataE,
    input  logic [`CORE_XLEN-1:0] rs2DataE,
    input  logic [`CORE_XLEN-1:0] immE,
    output logic [`CORE_XLEN-1:0] resultE,
    output logic [`CORE_XLEN-1:0] storeDataE,
    output logic                  redirectE,
    output logic [`CORE_XLEN-1:0] targetE
);

    localparam int                    shamtW = $clog2(`CORE_XLEN);
    localparam logic [`CORE_XLEN-1:0] pcStep = 4;

    logic [`CORE_XLEN-1:0] opB;
    logic [`CORE_XLEN-1:0] aluOut;
    logic                  taken;
    logic [`CORE_XLEN-1:0] threshold;
    logic [`CORE_XLEN-1:0] membrane;
    logic [`CORE_XLEN-1:0] membraneSum;
    logic                  fire;

    assign opB = opBSrcE ? immE : rs2DataE;

    always_comb begin
        case (aluFuncE)
            ALU_SUB: aluOut = rs1DataE - opB;
            ALU_AND: aluOut = rs1DataE & opB;
            ALU_OR:  aluOut = rs1DataE | opB;
            ALU_XOR: aluOut = rs1DataE ^ opB;
            ALU_SLT: aluOut = {{(`CORE_XLEN-1){1'b0}}, $signed(rs1DataE) < $signed(opB)};
            ALU_SLL: aluOut = rs1DataE << opB[shamtW-1:0];
            ALU_SRL: aluOut = rs1DataE >> opB[shamtW-1:0];
            default: aluOut = rs1DataE + opB;
        endcase
    end

    always_comb begin
        case (branchFunctT'(funct3E))
            BR_EQ:   taken = (rs1DataE == rs2DataE);
            BR_NE:   taken = (rs1DataE != rs2DataE);
            BR_LT:   taken = ($signed(rs1DataE) < $signed(rs2DataE));
            BR_GE:   taken = ($signed(rs1DataE) >= $signed(rs2DataE));
            default: taken = 1'b0;
        endcase
    end

    assign redirectE = jumpE || (branchE && taken);
    assign targetE   = pcE + immE;              // Same offset form for branches and jal.

    assign membraneSum = membrane + rs1DataE;
    assign fire        = enThresholdE && (membrane >= threshold);   // Unsigned compare.

    always_comb begin
        case (exPathE)
            PATH_LINK:     resultE = pcE + pcStep;
            PATH_MEMBRANE: resultE = membraneSum;
            PATH_FIRE:     resultE = {{(`CORE_XLEN-1){1'b0}}, fire};
            default:       resultE = aluOut;
        endcase
    end

    assign storeDataE = rs2DataE;

    // Neuron state commits when its instruction leaves execute.
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            threshold <= '0;
            membrane  <= '0;
        end else if (!stall) begin
            if (atWriteE)
                threshold <= rs1DataE;
            if (msWriteE)
                membrane <= membraneSum;
        end
    end

    // The decoder never marks one slot as both branch and jump.
    assert property (@(posedge clk) disable iff (reset) !(branchE && jumpE));

endmodule

// ==== coreFrontTop.sv ====
`timescale 1ns/1ps
`include "core_config.svh"

module coreFrontTop
    import pipePkg::*;
(
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  stall,
    input  logic [31:0]           instrD,
    input  logic [`CORE_XLEN-1:0] rs1DataD,
    input  logic [`CORE_XLEN-1:0] rs2DataD,
    output logic [`CORE_XLEN-1:0] fetchPc,
    output logic [4:0]            rs1,
    output logic [4:0]            rs2,
    output logic [`CORE_XLEN-1:0] resultE,
    output logic [`CORE_XLEN-1:0] storeDataE,
    output logic [4:0]            rdE,
    output logic                  regWriteExE,
    output logic                  regWriteWbE,
    output logic                  memWriteE
);

    logic                  validD, flushE, redirectE;
    logic [`CORE_XLEN-1:0] pcD, targetE, immD, pcE, rs1DataE, rs2DataE, immE;
    logic [4:0]            rd;
    logic                  regWriteExD, regWriteWbD, opBSrcD, memWriteD, enThresholdD;
    logic                  msWriteD, atWriteD, branchD, jumpD;
    logic                  opBSrcE, enThresholdE, msWriteE, atWriteE, branchE, jumpE;
    exPathT                exPathD, exPathE;
    aluFuncT               aluFuncD, aluFuncE;
    logic [2:0]            funct3D, funct3E;

    fetchSequencer fetchSequencer_i (
        .clk, .reset, .stall, .redirectE, .targetE, .fetchPc, .pcD, .validD, .flushE
    );

    controlDecoder controlDecoder_i (
        .instrD, .validD, .regWriteExD, .regWriteWbD, .opBSrcD, .memWriteD,
        .enThresholdD, .msWriteD, .atWriteD, .branchD, .jumpD, .exPathD, .aluFuncD,
        .funct3D, .immD, .rs1, .rs2, .rd
    );

    idExControlRegister idExControlRegister_i (
        .clk, .reset, .stallE(stall), .flushE,
        .regWriteExD, .regWriteWbD, .opBSrcD, .memWriteD, .enThresholdD, .msWriteD,
        .atWriteD, .branchD, .jumpD, .exPathD, .aluFuncD, .funct3D,
        .regWriteExE, .regWriteWbE, .opBSrcE, .memWriteE, .enThresholdE, .msWriteE,
        .atWriteE, .branchE, .jumpE, .exPathE, .aluFuncE, .funct3E
    );

    idExDataRegister idExDataRegister_i (
        .clk, .reset, .stallE(stall), .pcD, .rs1DataD, .rs2DataD, .immD, .rd,
        .pcE, .rs1DataE, .rs2DataE, .immE, .rdE
    );

    executeUnit executeUnit_i (
        .clk, .reset, .stall, .opBSrcE, .enThresholdE, .msWriteE, .atWriteE,
        .branchE, .jumpE, .exPathE, .aluFuncE, .funct3E, .pcE, .rs1DataE, .rs2DataE,
        .immE, .resultE, .storeDataE, .redirectE, .targetE
    );

endmodule

// ==== tbClockGen.sv ====
`timescale 1ns/1ps

module tbClockGen (
    output logic clk,
    output logic reset
);

    initial begin
        clk   = 1'b0;
        reset = 1'b1;
        repeat (2) @(posedge clk);
        reset <= 1'b0;                          // Released on a rising edge.
    end

    always #5 clk = ~clk;

endmodule

// ==== tbCoreFront.sv ====
`timescale 1ns/1ps
`include "core_config.svh"

module tbCoreFront
    import isaPkg::*;
    import pipePkg::*;
();

    localparam int  progLen   = 300;
    localparam int  progBytes = progLen * 4;
    localparam time timeoutNs = progLen * 4 * 10 + 4000;

    logic                  clk, reset, stall;
    logic [31:0]           instrD;
    logic [`CORE_XLEN-1:0] rs1DataD, rs2DataD, fetchPc, resultE, storeDataE;
    logic [4:0]            rs1, rs2, rdE;
    logic                  regWriteExE, regWriteWbE, memWriteE;

    logic [31:0]           lfsr;
    logic [31:0]           prog [0:progLen-1];
    logic [`CORE_XLEN-1:0] regs [0:31];
    logic [`CORE_XLEN-1:0] dataMem [logic [`CORE_XLEN-1:0]];
    logic [`CORE_XLEN-1:0] mFetchPc, mPcD, ePc, eA, eB, mThreshold, mMembrane;
    logic [`CORE_XLEN-1:0] xRes, xTarget;
    logic [31:0]           mInstrD, eInstr;
    logic                  mValidD, eValid, xWEx, xWWb, xMWr, xRedir, xSetTh, xAccum;
    logic [4:0]            xRd;

    tbClockGen tbClockGen_i (.clk, .reset);

    coreFrontTop coreFrontTop_i (
        .clk, .reset, .stall, .instrD, .rs1DataD, .rs2DataD, .fetchPc, .rs1, .rs2,
        .resultE, .storeDataE, .rdE, .regWriteExE, .regWriteWbE, .memWriteE
    );

    assign rs1DataD = regs[rs1];                // Register file read port.
    assign rs2DataD = regs[rs2];

    // Fibonacci LFSR x^32 + x^22 + x^2 + x + 1, one step per bit.
    function automatic logic [31:0] takeBits(input int n);
        logic [31:0] bits;
        bits = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = {lfsr[30:0], lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0]};
            bits = {bits[30:0], lfsr[0]};
        end
        return bits;
    endfunction

    function automatic logic [31:0] fetchWord(input logic [`CORE_XLEN-1:0] addr);
        if (addr < progBytes)
            return prog[addr >> 2];
        return `CORE_NOP_INSTR;
    endfunction

    function automatic logic [`CORE_XLEN-1:0] loadWord(input logic [`CORE_XLEN-1:0] addr);
        if (dataMem.exists(addr))
            return dataMem[addr];
        return (addr * 32'h9e37_79b1) ^ 32'h5a5a_c3c3;     // Never written.
    endfunction

    // funct7 and funct3 of the register-form ALU operations.
    function automatic logic [9:0] aluEncoding(input aluFuncT sel);
        case (sel)
            ALU_ADD: return {7'h00, 3'b000};
            ALU_SUB: return {7'h20, 3'b000};
            ALU_AND: return {7'h00, 3'b111};
            ALU_OR:  return {7'h00, 3'b110};
            ALU_XOR: return {7'h00, 3'b100};
            ALU_SLT: return {7'h00, 3'b010};
            ALU_SLL: return {7'h00, 3'b001};
            default: return {7'h00, 3'b101};
        endcase
    endfunction

    function automatic logic [31:0] aluResult(input logic [2:0] f3, input logic sub,
                                              input logic [31:0] a, input logic [31:0] b);
        case (f3)
            3'b000:  return sub ? a - b : a + b;
            3'b001:  return a << b[4:0];
            3'b010:  return {31'b0, $signed(a) < $signed(b)};
            3'b100:  return a ^ b;
            3'b101:  return a >> b[4:0];
            3'b110:  return a | b;
            default: return a & b;
        endcase
    endfunction

    task automatic abortRun(input string msg);
        $display("%s", msg);
        $display(">>> FAIL");
        $fatal(1, "Simulation stopped.");
    endtask

    task automatic checkWord(input logic [`CORE_XLEN-1:0] got, input logic [`CORE_XLEN-1:0] exp,
                             input string what);
        if (got !== exp)
            abortRun($sformatf("Error at %0t ns: %s is %h, expected %h", $time, what, got, exp));
    endtask

    task automatic checkFlag(input logic got, input logic exp, input string what);
        if (got !== exp)
            abortRun($sformatf("Error at %0t ns: %s is %b, expected %b", $time, what, got, exp));
    endtask

    task automatic checkReg(input logic [4:0] got, input logic [4:0] exp, input string what);
        if (got !== exp)
            abortRun($sformatf("Error at %0t ns: %s is %0d, expected %0d", $time, what, got, exp));
    endtask

    // Expected outputs of the instruction now in execute.
    task automatic predictExecute();
        opcodeT      op;
        logic [2:0]  f3;
        logic [31:0] immI, immS, immB, immJ;
        op     = opcodeT'(eInstr[6:0]);
        f3     = eInstr[14:12];
        immI   = {{20{eInstr[31]}}, eInstr[31:20]};
        immS   = {{20{eInstr[31]}}, eInstr[31:25], eInstr[11:7]};
        immB   = {{20{eInstr[31]}}, eInstr[7], eInstr[30:25], eInstr[11:8], 1'b0};
        immJ   = {{12{eInstr[31]}}, eInstr[19:12], eInstr[20], eInstr[30:21], 1'b0};
        xWEx   = 1'b0;
        xWWb   = 1'b0;
        xMWr   = 1'b0;
        xRedir = 1'b0;
        xSetTh = 1'b0;
        xAccum = 1'b0;
        xRes   = '0;
        xRd    = eInstr[11:7];
        xTarget = ePc + immB;
        if (eValid) begin
            case (op)
                OP_REG:    {xWEx, xRes} = {1'b1, aluResult(f3, eInstr[30], eA, eB)};
                OP_IMM:    {xWEx, xRes} = {1'b1, aluResult(f3, 1'b0, eA, immI)};
                OP_LOAD:   {xWWb, xRes} = {1'b1, eA + immI};
                OP_STORE:  {xMWr, xRes} = {1'b1, eA + immS};
                OP_BRANCH: begin
                    case (branchFunctT'(f3))
                        BR_EQ:   xRedir = (eA == eB);
                        BR_NE:   xRedir = (eA != eB);
                        BR_LT:   xRedir = ($signed(eA) < $signed(eB));
                        BR_GE:   xRedir = ($signed(eA) >= $signed(eB));
                        default: xRedir = 1'b0;
                    endcase
                end
                OP_JAL: begin
                    {xWEx, xRedir, xRes} = {2'b11, ePc + 32'd4};
                    xTarget = ePc + immJ;
                end
                OP_CUSTOM0: begin
                    case (neuronFunctT'(f3))
                        NR_SETTH: {xWEx, xSetTh, xRes} = {2'b11, eA};
                        NR_ACCUM: {xWEx, xAccum, xRes} = {2'b11, mMembrane + eA};
                        NR_FIRE:  {xWEx, xRes} = {1'b1, 31'b0, mMembrane >= mThreshold};
                        default:  ;
                    endcase
                end
                default: ;
            endcase
            if (xRd == 5'd0)
                {xWEx, xWWb} = 2'b00;
        end
    endtask

    // Memory side of the testbench and the two-stage model, stepped on unstalled edges.
    always @(posedge clk) begin
        if (!reset && !stall) begin
            if (xWEx)
                regs[xRd] <= xRes;
            if (xWWb)
                regs[xRd] <= loadWord(xRes);
            if (xMWr)
                dataMem[xRes] = eB;
            if (xSetTh)
                mThreshold = eA;
            if (xAccum)
                mMembrane = xRes;
            eValid   = mValidD && !xRedir;      // Flush kills the slot in decode.
            eInstr   = mInstrD;
            ePc      = mPcD;
            eA       = regs[mInstrD[19:15]];
            eB       = regs[mInstrD[24:20]];
            mInstrD  = fetchWord(mFetchPc);
            mPcD     = mFetchPc;
            mValidD  = !xRedir;
            mFetchPc = xRedir ? xTarget : mFetchPc + 32'd4;
            instrD   <= fetchWord(fetchPc);
            predictExecute();
        end
        if (!reset)
            stall <= (takeBits(2) == 0);
    end

    always @(negedge clk) begin
        if (!reset) begin
            checkWord(fetchPc, mFetchPc, "fetchPc");
            checkReg(rs1, mInstrD[19:15], "rs1");
            checkReg(rs2, mInstrD[24:20], "rs2");
            checkFlag(regWriteExE, xWEx, "regWriteExE");
            checkFlag(regWriteWbE, xWWb, "regWriteWbE");
            checkFlag(memWriteE, xMWr, "memWriteE");
            if (xWEx || xWWb || xMWr)
                checkWord(resultE, xRes, "resultE");
            if (xWEx || xWWb)
                checkReg(rdE, xRd, "rdE");
            if (xMWr)
                checkWord(storeDataE, eB, "storeDataE");
        end
    end

    initial begin
        logic [9:0]  enc;
        logic [11:0] imm, off;
        logic [4:0]  rdF, rs1F, rs2F;
        logic [2:0]  nf;
        logic [24:0] junk;
        lfsr   = 32'h06889fac;
        stall  <= 1'b0;
        instrD <= `CORE_NOP_INSTR;
        regs[0] <= '0;
        for (int r = 1; r < 32; r++)
            regs[r] <= takeBits(32);
        for (int i = 0; i < progLen; i++) begin
            rdF  = 5'(takeBits(5));
            rs1F = 5'(takeBits(5));
            rs2F = 5'(takeBits(5));
            imm  = 12'(takeBits(12));
            off  = 12'((takeBits(3) + 1) << 2);     // Forward targets only.
            nf   = 3'(takeBits(3));
            junk = 25'(takeBits(25));
            enc  = aluEncoding(aluFuncT'(takeBits(3)));
            if (enc[1:0] == 2'b01)
                imm = {7'b0, rs2F};                 // Shift amount.
            case (takeBits(4))
                0, 1, 2: prog[i] = {enc[9:3], rs2F, rs1F, enc[2:0], rdF, OP_REG};
                3, 4, 5: prog[i] = {imm, rs1F, enc[2:0], rdF, OP_IMM};
                6:       prog[i] = {imm, rs1F, 3'b010, rdF, OP_LOAD};
                7:       prog[i] = {imm[11:5], rs2F, rs1F, 3'b010, imm[4:0], OP_STORE};
                8:  prog[i] = {1'b0, off[10:5], rs2F, rs1F, nf[1], 1'b0, nf[0], off[4:1], 1'b0,
                               OP_BRANCH};
                9:  prog[i] = {1'b0, off[10:5], rs1F, rs1F, nf[1], 1'b0, nf[0], off[4:1], 1'b0,
                               OP_BRANCH};
                10:      prog[i] = {1'b0, off[10:1], 1'b0, 8'b0, rdF, OP_JAL};
                11:      prog[i] = {7'b0, rs2F, rs1F, NR_SETTH, rdF, OP_CUSTOM0};
                12, 13:  prog[i] = {7'b0, rs2F, rs1F, NR_ACCUM, rdF, OP_CUSTOM0};
                14:      prog[i] = {7'b0, rs2F, rs1F, NR_FIRE, rdF, OP_CUSTOM0};
                default: prog[i] = nf[2] ? {junk, 7'b1110111}
                                         : {7'b0, rs2F, rs1F, 1'b1, nf[1:0], rdF, OP_CUSTOM0};
            endcase
        end
        mFetchPc   = `CORE_RESET_PC;
        mPcD       = `CORE_RESET_PC;
        mValidD    = 1'b0;
        mInstrD    = `CORE_NOP_INSTR;
        eValid     = 1'b0;
        eInstr     = `CORE_NOP_INSTR;
        ePc        = '0;
        eA         = '0;
        eB         = '0;
        mThreshold = '0;
        mMembrane  = '0;
        predictExecute();
        do @(negedge clk); while (reset);
        while (mFetchPc < progBytes + 12)
            @(negedge clk);
        @(negedge clk);
        $display(">>> PASS");
        $finish;
    end

    initial begin
        #(timeoutNs);
        abortRun("Timeout: the program did not run to its end in the expected time.");
    end

endmodule

// ==== sources.f ====
+incdir+.
isaPkg.sv
pipePkg.sv
fetchSequencer.sv
controlDecoder.sv
idExControlRegister.sv
idExDataRegister.sv
executeUnit.sv
coreFrontTop.sv
tbClockGen.sv
tbCoreFront.sv
